/* files.f */
rtl/uart_pkg.sv
rtl/baud_gen.sv
rtl/rx_bit_timer.sv
rtl/rx_controller.sv
rtl/rx_shift_register.sv
rtl/rx_fifo.sv
rtl/uart_wb_regs.sv
rtl/uart_rx_top.sv
tb/uart_rx_properties.sv
tb/uart_rx_tb.sv

/* rtl/baud_gen.sv */
`timescale 1ns/10ps

module baud_gen (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic [uart_pkg::DIV_W-1:0] div_i,
	output logic                       tick_o
);

	import uart_pkg::*;

	logic [DIV_W-1:0] cnt_q;

	// Counts div_i down to zero, so one tick every div_i+1 clocks.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			cnt_q <= '0;
		end else if (cnt_q == '0) begin
			cnt_q <= div_i; // New divisor is picked up here.
		end else begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	assign tick_o = (cnt_q == '0);

endmodule

/* rtl/rx_bit_timer.sv */
`timescale 1ns/10ps

module rx_bit_timer (
	input  logic       clk,
	input  logic       reset_n,
	input  logic       rx_i,
	input  logic       tick_i,
	input  logic       phase_clr_i,
	input  logic       bit_inc_i,
	output logic       start_edge_o,
	output logic       sample_stb_o,
	output logic       line_bit_o,
	output logic [3:0] bit_idx_o
);

	import uart_pkg::*;

	localparam logic [3:0] PHASE_LAST = 4'(OVERSAMPLE - 1);
	localparam logic [3:0] PHASE_MID  = 4'(MID_SAMPLE);

	logic       rx_meta_q;
	logic       rx_sync_q;
	logic       rx_prev_q;
	logic [3:0] phase_q;
	logic [3:0] bit_idx_q;

	// Line idles high, so the flops reset to 1.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rx_meta_q <= 1'b1;
			rx_sync_q <= 1'b1;
			rx_prev_q <= 1'b1;
		end else begin
			rx_meta_q <= rx_i;
			rx_sync_q <= rx_meta_q;
			rx_prev_q <= rx_sync_q;
		end
	end

	assign start_edge_o = rx_prev_q & ~rx_sync_q; // Falling edge.
	assign line_bit_o   = rx_sync_q;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			phase_q <= '0;
		end else if (phase_clr_i) begin
			phase_q <= '0;
		end else if (tick_i) begin
			phase_q <= (phase_q == PHASE_LAST) ? 4'd0 : phase_q + 4'd1;
		end
	end

	assign sample_stb_o = tick_i && (phase_q == PHASE_MID);

	// Bit position within the frame.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			bit_idx_q <= '0;
		end else if (phase_clr_i) begin
			bit_idx_q <= '0;
		end else if (bit_inc_i) begin
			bit_idx_q <= bit_idx_q + 4'd1;
		end
	end

	assign bit_idx_o = bit_idx_q;

endmodule

/* rtl/rx_controller.sv */
`timescale 1ns/10ps

module rx_controller (
	input  logic                 clk,
	input  logic                 reset_n,
	input  uart_pkg::uart_cfg_t  cfg_i,
	input  logic                 start_edge_i,
	input  logic                 sample_stb_i,
	input  logic                 line_bit_i,
	input  logic                 parity_i,
	input  logic                 fifo_full_i,
	input  logic [3:0]           bit_idx_i,
	input  logic [7:0]           data_i,
	output logic                 phase_clr_o,
	output logic                 bit_inc_o,
	output logic                 shift_en_o,
	output logic                 shift_clr_o,
	output logic                 push_o,
	output logic                 overrun_o,
	output uart_pkg::rx_frame_t  frame_o
);

	import uart_pkg::*;

	typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP1, STOP2} state_t;

	state_t state_q;
	state_t state_d;
	logic   parity_err_q;
	logic   stop_err_q;
	logic   last_data;
	logic   frame_end;

	assign last_data = (bit_idx_i == ({2'b00, cfg_i.data_bits} + 4'd4));
	assign frame_end = sample_stb_i &&
		((state_q == STOP1 && !cfg_i.two_stop) || state_q == STOP2);

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:   if (cfg_i.rx_en && start_edge_i) state_d = START;
			START:  if (sample_stb_i) state_d = line_bit_i ? IDLE : DATA; // High means a glitch.
			DATA:   if (sample_stb_i && last_data) state_d = cfg_i.parity_en ? PARITY : STOP1;
			PARITY: if (sample_stb_i) state_d = STOP1;
			STOP1:  if (sample_stb_i) state_d = cfg_i.two_stop ? STOP2 : IDLE;
			STOP2:  if (sample_stb_i) state_d = IDLE;
			default: state_d = IDLE;
		endcase
		if (!cfg_i.rx_en) begin
			state_d = IDLE;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state_q      <= IDLE;
			parity_err_q <= 1'b0;
			stop_err_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == IDLE) begin
				parity_err_q <= 1'b0;
				stop_err_q   <= 1'b0;
			end
			if (state_q == PARITY && sample_stb_i) begin
				parity_err_q <= parity_i ^ line_bit_i ^ cfg_i.parity_odd;
			end
			if (state_q == STOP1 && sample_stb_i) begin
				stop_err_q <= !line_bit_i;
			end
		end
	end

	assign phase_clr_o = (state_q == IDLE) && cfg_i.rx_en && start_edge_i;
	assign shift_clr_o = (state_q == START) && sample_stb_i;
	assign shift_en_o  = (state_q == DATA) && sample_stb_i;
	assign bit_inc_o   = shift_en_o;

	// The last stop sample is folded in directly.
	assign frame_o.data       = data_i;
	assign frame_o.parity_err = parity_err_q;
	assign frame_o.stop_err   = stop_err_q | !line_bit_i;

	assign push_o    = frame_end && !fifo_full_i;
	assign overrun_o = frame_end && fifo_full_i; // Frame is dropped.

endmodule

/* rtl/rx_fifo.sv */
`timescale 1ns/10ps

module rx_fifo (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                push_i,
	input  logic                pop_i,
	input  uart_pkg::rx_frame_t din_i,
	output uart_pkg::rx_frame_t dout_o,
	output logic                empty_o,
	output logic                full_o
);

	import uart_pkg::*;

	localparam logic [FIFO_AW:0] COUNT_FULL = (FIFO_AW + 1)'(FIFO_DEPTH);

	rx_frame_t          mem_q [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr_q;
	logic [FIFO_AW-1:0] rd_ptr_q;
	logic [FIFO_AW:0]   count_q;
	logic               do_push;
	logic               do_pop;

	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem_q[wr_ptr_q] <= din_i;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	assign dout_o  = mem_q[rd_ptr_q]; // Head is visible without a pop.
	assign empty_o = (count_q == '0);
	assign full_o  = (count_q == COUNT_FULL);

endmodule

/* rtl/rx_shift_register.sv */
`timescale 1ns/10ps

module rx_shift_register (
	input  logic       clk,
	input  logic       reset_n,
	input  logic       shift_en_i,
	input  logic       shift_clr_i,
	input  logic       bit_i,
	input  logic [1:0] data_bits_i,
	output logic [7:0] data_o,
	output logic       parity_o
);

	logic [7:0] sr_q;
	logic       parity_q;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			sr_q     <= '0;
			parity_q <= 1'b0;
		end else if (shift_clr_i) begin
			sr_q     <= '0;
			parity_q <= 1'b0;
		end else if (shift_en_i) begin
			sr_q     <= {bit_i, sr_q[7:1]}; // LSB arrives first.
			parity_q <= parity_q ^ bit_i;
		end
	end

	// Short frames sit in the top bits.
	assign data_o   = sr_q >> (2'd3 - data_bits_i);
	assign parity_o = parity_q;

endmodule

/* rtl/uart_pkg.sv */
package uart_pkg;

	localparam int DIV_W      = 16;
	localparam int OVERSAMPLE = 16;
	localparam int MID_SAMPLE = 7;
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AW    = 2;

	// Word indices taken from adr_i[3:2].
	localparam logic [1:0] REG_CTRL   = 2'd0;
	localparam logic [1:0] REG_DIV    = 2'd1;
	localparam logic [1:0] REG_STATUS = 2'd2;
	localparam logic [1:0] REG_RXDATA = 2'd3;

	// Roughly 115200 baud from a 100 MHz clock.
	localparam logic [DIV_W-1:0] RESET_DIV = 16'd53;

	typedef struct packed {
		logic       rx_en;
		logic       parity_en;
		logic       parity_odd; // 1 selects odd parity.
		logic       two_stop;
		logic [1:0] data_bits;  // 0..3 encode 5..8 bits.
	} uart_cfg_t;

	typedef struct packed {
		logic [7:0] data;
		logic       parity_err;
		logic       stop_err;
	} rx_frame_t;

endpackage

/* rtl/uart_rx_top.sv */
`timescale 1ns/10ps

module uart_rx_top (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        rx_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [3:0]  adr_i,
	input  logic [31:0] dat_i,
	output logic [31:0] dat_o,
	output logic        ack_o
);

	import uart_pkg::*;

	uart_cfg_t        cfg;
	logic [DIV_W-1:0] div;
	logic             tick;
	logic             start_edge;
	logic             sample_stb;
	logic             line_bit;
	logic [3:0]       bit_idx;
	logic             phase_clr;
	logic             bit_inc;
	logic             shift_en;
	logic             shift_clr;
	logic [7:0]       rx_data;
	logic             rx_parity;
	logic             push;
	logic             pop;
	logic             overrun;
	rx_frame_t        frame;
	rx_frame_t        fifo_dout;
	logic             fifo_empty;
	logic             fifo_full;

	baud_gen i_baud_gen (
		.clk     (clk),
		.reset_n (reset_n),
		.div_i   (div),
		.tick_o  (tick)
	);

	rx_bit_timer i_rx_bit_timer (
		.clk          (clk),
		.reset_n      (reset_n),
		.rx_i         (rx_i),
		.tick_i       (tick),
		.phase_clr_i  (phase_clr),
		.bit_inc_i    (bit_inc),
		.start_edge_o (start_edge),
		.sample_stb_o (sample_stb),
		.line_bit_o   (line_bit),
		.bit_idx_o    (bit_idx)
	);

	rx_controller i_rx_controller (
		.clk          (clk),
		.reset_n      (reset_n),
		.cfg_i        (cfg),
		.start_edge_i (start_edge),
		.sample_stb_i (sample_stb),
		.line_bit_i   (line_bit),
		.parity_i     (rx_parity),
		.fifo_full_i  (fifo_full),
		.bit_idx_i    (bit_idx),
		.data_i       (rx_data),
		.phase_clr_o  (phase_clr),
		.bit_inc_o    (bit_inc),
		.shift_en_o   (shift_en),
		.shift_clr_o  (shift_clr),
		.push_o       (push),
		.overrun_o    (overrun),
		.frame_o      (frame)
	);

	rx_shift_register i_rx_shift_register (
		.clk         (clk),
		.reset_n     (reset_n),
		.shift_en_i  (shift_en),
		.shift_clr_i (shift_clr),
		.bit_i       (line_bit),
		.data_bits_i (cfg.data_bits),
		.data_o      (rx_data),
		.parity_o    (rx_parity)
	);

	rx_fifo i_rx_fifo (
		.clk     (clk),
		.reset_n (reset_n),
		.push_i  (push),
		.pop_i   (pop),
		.din_i   (frame),
		.dout_o  (fifo_dout),
		.empty_o (fifo_empty),
		.full_o  (fifo_full)
	);

	uart_wb_regs i_uart_wb_regs (
		.clk          (clk),
		.reset_n      (reset_n),
		.cyc_i        (cyc_i),
		.stb_i        (stb_i),
		.we_i         (we_i),
		.adr_i        (adr_i),
		.dat_i        (dat_i),
		.dat_o        (dat_o),
		.ack_o        (ack_o),
		.cfg_o        (cfg),
		.div_o        (div),
		.fifo_dout_i  (fifo_dout),
		.fifo_empty_i (fifo_empty),
		.fifo_full_i  (fifo_full),
		.overrun_i    (overrun),
		.pop_o        (pop)
	);

endmodule

/* rtl/uart_wb_regs.sv */
`timescale 1ns/10ps

module uart_wb_regs (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       cyc_i,
	input  logic                       stb_i,
	input  logic                       we_i,
	input  logic [3:0]                 adr_i,
	input  logic [31:0]                dat_i,
	output logic [31:0]                dat_o,
	output logic                       ack_o,
	output uart_pkg::uart_cfg_t        cfg_o,
	output logic [uart_pkg::DIV_W-1:0] div_o,
	input  uart_pkg::rx_frame_t        fifo_dout_i,
	input  logic                       fifo_empty_i,
	input  logic                       fifo_full_i,
	input  logic                       overrun_i,
	output logic                       pop_o
);

	import uart_pkg::*;

	localparam int CFG_W = $bits(uart_cfg_t);

	uart_cfg_t        cfg_q;
	logic [DIV_W-1:0] div_q;
	logic             overrun_q;
	logic             req;
	logic [1:0]       word;
	logic [31:0]      rd_data;

	// No new request while ack is high, so ack lasts one clock.
	assign req  = cyc_i && stb_i && !ack_o;
	assign word = adr_i[3:2];

	always_comb begin
		case (word)
			REG_CTRL:   rd_data = {{(32 - CFG_W){1'b0}}, cfg_q};
			REG_DIV:    rd_data = {{(32 - DIV_W){1'b0}}, div_q};
			REG_STATUS: rd_data = {29'd0, overrun_q, fifo_full_i, !fifo_empty_i};
			default: begin
				if (fifo_empty_i) begin
					rd_data = '0;
				end else begin
					rd_data = {21'd0, 1'b1, fifo_dout_i.stop_err,
						fifo_dout_i.parity_err, fifo_dout_i.data};
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			ack_o <= 1'b0;
			dat_o <= '0;
			cfg_q <= '0; // Receiver starts disabled.
			div_q <= RESET_DIV;
		end else begin
			ack_o <= req;
			if (req && !we_i) begin
				dat_o <= rd_data;
			end
			if (req && we_i) begin
				case (word)
					REG_CTRL: cfg_q <= uart_cfg_t'(dat_i[CFG_W-1:0]);
					REG_DIV:  div_q <= dat_i[DIV_W-1:0];
					default:  ;
				endcase
			end
		end
	end

	// Sticky overrun. A new overrun beats the clearing read.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			overrun_q <= 1'b0;
		end else if (overrun_i) begin
			overrun_q <= 1'b1;
		end else if (req && !we_i && word == REG_STATUS) begin
			overrun_q <= 1'b0;
		end
	end

	assign pop_o = req && !we_i && (word == REG_RXDATA) && !fifo_empty_i;
	assign cfg_o = cfg_q;
	assign div_o = div_q;

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module uart_rx_tb -f files.f || exit 1
out=$(./obj_dir/Vuart_rx_tb 2>&1) ; printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "RESULT: PASS" && exit 0 || exit 1

/* tb/uart_rx_properties.sv */
`timescale 1ns/10ps

module uart_rx_properties (
	input logic clk,
	input logic reset_n,
	input logic cyc_i,
	input logic stb_i,
	input logic ack_i
);

	// An ack answers a request seen one clock earlier.
	ack_after_request: assert property (@(posedge clk) disable iff (!reset_n)
		ack_i |-> $past(cyc_i && stb_i))
		else $error("ack_o raised without a preceding request");

	ack_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
		ack_i |=> !ack_i)
		else $error("ack_o high in two consecutive cycles");

	ack_low_after_reset: assert property (@(posedge clk) $rose(reset_n) |-> !ack_i)
		else $error("ack_o high when reset is released");

endmodule

bind uart_rx_top uart_rx_properties i_uart_rx_properties (
	.clk     (clk),
	.reset_n (reset_n),
	.cyc_i   (cyc_i),
	.stb_i   (stb_i),
	.ack_i   (ack_o)
);

/* tb/uart_rx_tb.sv */
`timescale 1ns/10ps

module uart_rx_tb;

	import uart_pkg::*;

	localparam logic [31:0] TB_DIV     = 32'd3;
	localparam int          BIT_CLKS   = (int'(TB_DIV) + 1) * OVERSAMPLE;
	localparam int          FRAME_CLKS = 12 * BIT_CLKS; // Start, 8 data, parity, 2 stop.
	localparam int          NUM_FRAMES = 25;
	localparam int          WATCHDOG_NS = (NUM_FRAMES + 10) * FRAME_CLKS * 10;
	localparam logic [31:0] LFSR_SEED  = 32'h8078f713;
	localparam logic [31:0] LFSR_TAPS  = 32'h80200003;

	logic        clk;
	logic        reset_n;
	logic        rx_line;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [3:0]  wb_adr;
	logic [31:0] wb_wdata;
	logic [31:0] wb_rdata;
	logic        wb_ack;
	int          errors;
	int          tests_run;
	logic [31:0] lfsr_state;

	uart_rx_top i_uart_rx_top (
		.clk     (clk),
		.reset_n (reset_n),
		.rx_i    (rx_line),
		.cyc_i   (wb_cyc),
		.stb_i   (wb_stb),
		.we_i    (wb_we),
		.adr_i   (wb_adr),
		.dat_i   (wb_wdata),
		.dat_o   (wb_rdata),
		.ack_o   (wb_ack)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic random_byte(output logic [7:0] value);
		value = '0;
		for (int i = 0; i < 8; i++) begin
			value = {value[6:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [7:0] width_mask(input logic [1:0] code);
		return 8'((9'd1 << ({2'b00, code} + 4'd5)) - 9'd1); // Code 0 means 5 bits.
	endfunction

	function automatic uart_cfg_t make_cfg(input logic en, input logic pe, input logic odd,
		input logic two, input logic [1:0] code);
		uart_cfg_t cfg;
		cfg.rx_en      = en;
		cfg.parity_en  = pe;
		cfg.parity_odd = odd;
		cfg.two_stop   = two;
		cfg.data_bits  = code;
		return cfg;
	endfunction

	function automatic rx_frame_t make_frame(input logic [7:0] data, input logic [1:0] code,
		input logic perr, input logic serr);
		rx_frame_t f;
		f.data       = data & width_mask(code);
		f.parity_err = perr;
		f.stop_err   = serr;
		return f;
	endfunction

	task automatic check_frame(input rx_frame_t got, input rx_frame_t exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s got data %02h perr %0b serr %0b, expected %02h %0b %0b",
				$time, what, got.data, got.parity_err, got.stop_err,
				exp.data, exp.parity_err, exp.stop_err);
			errors++;
		end
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s read %08h, expected %08h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is %0b, expected %0b", $time, what, got, exp);
			errors++;
		end
	endtask

	// Called on a falling edge, returns on a falling edge.
	task automatic wb_access(input logic write, input logic [1:0] word,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = write;
		wb_adr   = {word, 2'b00};
		wb_wdata = wdata;
		waited   = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_ack && waited < 16);
		if (!wb_ack) begin
			$display("Bus timeout: no ack for the access to register %0d", word);
			errors++;
		end
		rdata  = wb_rdata;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge clk);
	endtask

	task automatic wb_write(input logic [1:0] word, input logic [31:0] data);
		logic [31:0] unused;
		wb_access(1'b1, word, data, unused);
	endtask

	task automatic wb_read(input logic [1:0] word, output logic [31:0] data);
		wb_access(1'b0, word, 32'd0, data);
	endtask

	task automatic drive_bit(input logic b);
		rx_line = b;
		repeat (BIT_CLKS) @(negedge clk);
	endtask

	// bad_stop selects which stop bit is sent as 0 (1 or 2), 0 for none.
	task automatic send_frame(input logic [7:0] data, input uart_cfg_t cfg,
		input logic bad_parity, input int bad_stop);
		int nbits;
		nbits = int'(cfg.data_bits) + 5;
		drive_bit(1'b0);
		for (int i = 0; i < nbits; i++) begin
			drive_bit(data[i]);
		end
		if (cfg.parity_en) begin
			drive_bit((^(data & width_mask(cfg.data_bits))) ^ cfg.parity_odd ^ bad_parity);
		end
		drive_bit(bad_stop != 1);
		if (cfg.two_stop) begin
			drive_bit(bad_stop != 2);
		end
		drive_bit(1'b1); // Idle gap so the next start bit has an edge.
	endtask

	task automatic read_frame(input rx_frame_t exp, input string what);
		logic [31:0] w;
		rx_frame_t   got;
		wb_read(REG_RXDATA, w);
		got.data       = w[7:0];
		got.parity_err = w[8];
		got.stop_err   = w[9];
		check_flag(w[10], 1'b1, {what, " valid"});
		check_frame(got, exp, what);
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		$display("Test %-14s %s", name, (errors == errors_before) ? "passed" : "failed");
	endtask

	task automatic test_registers();
		int          e0;
		logic [31:0] w;
		uart_cfg_t   cfg;
		e0 = errors;
		wb_read(REG_STATUS, w);
		check_word(w, 32'd0, "status after reset");
		cfg = make_cfg(1'b0, 1'b1, 1'b1, 1'b0, 2'd2);
		wb_write(REG_CTRL, {26'd0, cfg});
		wb_read(REG_CTRL, w);
		check_word(w, {26'd0, cfg}, "ctrl readback");
		wb_write(REG_DIV, TB_DIV);
		// The reset divisor has to run out before the new one is loaded.
		repeat (int'(RESET_DIV) + 2) @(negedge clk);
		wb_read(REG_DIV, w);
		check_word(w, TB_DIV, "div readback");
		report_test("registers", e0);
	endtask

	task automatic test_random_8n1();
		int         e0;
		logic [7:0] d;
		uart_cfg_t  cfg;
		e0  = errors;
		cfg = make_cfg(1'b1, 1'b0, 1'b0, 1'b0, 2'd3);
		wb_write(REG_CTRL, {26'd0, cfg});
		repeat (4) begin
			random_byte(d);
			send_frame(d, cfg, 1'b0, 0);
			read_frame(make_frame(d, 2'd3, 1'b0, 1'b0), "8N1 frame");
		end
		report_test("random_8n1", e0);
	endtask

	task automatic test_widths_parity();
		int         e0;
		logic [7:0] d;
		uart_cfg_t  cfg;
		e0 = errors;
		for (int k = 0; k < 8; k++) begin
			cfg = make_cfg(1'b1, 1'b1, k[0], 1'b1, k[2:1]);
			wb_write(REG_CTRL, {26'd0, cfg});
			random_byte(d);
			send_frame(d, cfg, 1'b0, 0);
			read_frame(make_frame(d, k[2:1], 1'b0, 1'b0), "width/parity frame");
		end
		report_test("widths_parity", e0);
	endtask

	task automatic test_errors();
		int         e0;
		logic [7:0] d;
		uart_cfg_t  cfg;
		e0  = errors;
		cfg = make_cfg(1'b1, 1'b1, 1'b0, 1'b1, 2'd3);
		wb_write(REG_CTRL, {26'd0, cfg});
		random_byte(d);
		send_frame(d, cfg, 1'b1, 0);
		read_frame(make_frame(d, 2'd3, 1'b1, 1'b0), "bad parity frame");
		for (int s = 1; s <= 2; s++) begin
			random_byte(d);
			send_frame(d, cfg, 1'b0, s);
			read_frame(make_frame(d, 2'd3, 1'b0, 1'b1), "bad stop frame");
		end
		report_test("errors", e0);
	endtask

	task automatic test_overrun();
		int          e0;
		logic [7:0]  d [5];
		logic [31:0] w;
		uart_cfg_t   cfg;
		e0  = errors;
		cfg = make_cfg(1'b1, 1'b0, 1'b0, 1'b0, 2'd3);
		wb_write(REG_CTRL, {26'd0, cfg});
		for (int i = 0; i < 5; i++) begin
			random_byte(d[i]);
			send_frame(d[i], cfg, 1'b0, 0);
		end
		wb_read(REG_STATUS, w);
		check_word(w, 32'd7, "status with overrun");
		wb_read(REG_STATUS, w);
		check_word(w, 32'd3, "status after clear");
		for (int i = 0; i < 4; i++) begin
			read_frame(make_frame(d[i], 2'd3, 1'b0, 1'b0), "queued frame");
		end
		wb_read(REG_RXDATA, w);
		check_word(w, 32'd0, "rxdata when empty");
		wb_read(REG_STATUS, w);
		check_word(w, 32'd0, "status after drain");
		report_test("overrun", e0);
	endtask

	task automatic test_no_frame();
		int          e0;
		logic [7:0]  d;
		logic [31:0] w;
		uart_cfg_t   cfg;
		e0  = errors;
		cfg = make_cfg(1'b1, 1'b0, 1'b0, 1'b0, 2'd3);
		wb_write(REG_CTRL, {26'd0, cfg});
		rx_line = 1'b0; // Shorter than half a bit.
		repeat (BIT_CLKS / 3) @(negedge clk);
		drive_bit(1'b1);
		drive_bit(1'b1);
		wb_read(REG_STATUS, w);
		check_word(w, 32'd0, "status after glitch");
		cfg.rx_en = 1'b0;
		wb_write(REG_CTRL, {26'd0, cfg});
		repeat (2) begin
			random_byte(d);
			send_frame(d, cfg, 1'b0, 0);
		end
		wb_read(REG_STATUS, w);
		check_word(w, 32'd0, "status with receiver off");
		report_test("no_frame", e0);
	endtask

	initial begin
		rx_line    = 1'b1;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_wdata   = '0;
		reset_n    = 1'b0;
		errors     = 0;
		tests_run  = 0;
		lfsr_state = LFSR_SEED;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		@(negedge clk);
		test_registers();
		test_random_8n1();
		test_widths_parity();
		test_errors();
		test_overrun();
		test_no_frame();
		$display("Tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
